// File: design/erx_defines.svh
`ifndef ERX_DEFINES_SVH
`define ERX_DEFINES_SVH

//################################################
//# link format
//################################################

`define ERX_WORD_W      16    // one ddr word per rx_lclk edge
`define ERX_SLOTS       7     // words in a full packet
`define ERX_SAMPLE_W    112   // ERX_SLOTS * ERX_WORD_W

// emesh transaction
`define ERX_PW          104

// burst packets refill from slot 3 upward
// slots 0 to 2 keep the header of the packet before
`define ERX_BURST_SLOT  3

`endif

// File: design/erx_pkg.sv
`default_nettype none

`include "erx_defines.svh"

package erx_pkg;

   // one word as registered off the ddr sampler
   typedef logic [`ERX_WORD_W-1:0]   word_t;

   // one-hot write pointer, bit k selects slot k
   typedef logic [`ERX_SLOTS-1:0]    slot_t;

   // raw sample, slot k at bits 16k+15 down to 16k
   typedef logic [`ERX_SAMPLE_W-1:0] sample_t;

   // reordered transaction
   // srcaddr, data, dstaddr, ctrlmode, datamode, write, access
   // from msb down
   typedef logic [`ERX_PW-1:0]       packet_t;

endpackage

`default_nettype wire

// File: design/erx_frame_fsm.sv
`timescale 1ns/10ps
`default_nettype none

`include "erx_defines.svh"

module erx_frame_fsm
(
   input  wire              rx_lclk,
   input  wire              erx_io_nreset,
   input  wire              frame_q,       // registered frame level
   input  wire erx_pkg::slot_t slot,       // write pointer from counter
   output logic             slot_clear,    // back to slot 0
   output logic             slot_reload,   // jump to burst slot
   output logic             access,        // one cycle per full packet
   output logic             burst          // held per packet
);

   typedef enum logic [1:0]
   {
      st_idle,    // frame low
      st_first,   // first packet of the frame in flight
      st_burst    // every later packet is a burst
   } state_t;

   state_t state;
   logic   last_slot;

   //################################################
   //# pointer steering
   //################################################

   assign last_slot   = slot[`ERX_SLOTS-1];    // only the top bit matters here
   assign slot_clear  = ~frame_q;              // restart on every low cycle
   assign slot_reload = last_slot & frame_q;   // packet done, frame still up

   //################################################
   //# frame state
   //################################################

   always_ff @(posedge rx_lclk or negedge erx_io_nreset)
   begin
      if (!erx_io_nreset)
         state <= st_idle;
      else if (!frame_q)
         state <= st_idle;                     // frame dropped
      else
      begin
         case (state)
            st_idle  : state <= st_first;
            st_first : if (access) state <= st_burst;   // first packet out
            default  : state <= st_burst;               // stay until frame drops
         endcase
      end
   end

   // access lines up with the last word landing in the sample
   // burst is sampled once per packet so it stays put for the mapper
   always_ff @(posedge rx_lclk or negedge erx_io_nreset)
   begin
      if (!erx_io_nreset)
      begin
         access <= 1'b0;
         burst  <= 1'b0;
      end
      else
      begin
         access <= slot_reload;
         if (slot_reload)
            burst <= (state == st_burst);      // 0 for first packet
         else if (!frame_q)
            burst <= 1'b0;
      end
   end

   // even a burst needs four slots, so no two access cycles in a row
   a_access_pulse : assert property (@(posedge rx_lclk) disable iff (!erx_io_nreset)
      access |=> !access);

endmodule

`default_nettype wire

// File: design/erx_slot_counter.sv
`timescale 1ns/10ps
`default_nettype none

`include "erx_defines.svh"

module erx_slot_counter
(
   input  wire              rx_lclk,
   input  wire              erx_io_nreset,
   input  wire              slot_clear,    // frame low
   input  wire              slot_reload,   // last slot with frame high
   output erx_pkg::slot_t   slot           // one-hot once the frame has been low
);

   import erx_pkg::*;

   //################################################
   //# one-hot write pointer
   //################################################

   // clear wins over reload
   // fsm never raises both together
   // stays all zero after reset until the frame first goes low
   always_ff @(posedge rx_lclk or negedge erx_io_nreset)
   begin
      if (!erx_io_nreset)
         slot <= '0;
      else if (slot_clear)
         slot <= slot_t'(1);                            // new frame starts at slot 0
      else if (slot_reload)
         slot <= slot_t'(1) << `ERX_BURST_SLOT;         // anticipate burst
      else
         slot <= {slot[`ERX_SLOTS-2:0], 1'b0};          // next word
   end

   // a shift out of slot 6 without reload would leave no lane selected
   // once a lane is selected there is always exactly one
   a_slot_onehot : assert property (@(posedge rx_lclk) disable iff (!erx_io_nreset)
      (slot != '0) |=> $onehot(slot));

endmodule

`default_nettype wire

// File: design/erx_sample_assembler.sv
`timescale 1ns/10ps
`default_nettype none

`include "erx_defines.svh"

module erx_sample_assembler
(
   input  wire              rx_lclk,
   input  wire              erx_io_nreset,
   input  wire              rx_frame,      // frame level from the pins
   input  wire erx_pkg::word_t rx_word,    // ddr word from the pins
   input  wire erx_pkg::slot_t slot,       // lane to write this cycle
   output logic             frame_q,       // frame, one register later
   output erx_pkg::sample_t sample         // 112 bit raw sample
);

   import erx_pkg::*;

   word_t word_q;                          // word, aligned with frame_q

   //################################################
   //# input register
   //################################################

   // frame is control, it drives the pointer
   always_ff @(posedge rx_lclk or negedge erx_io_nreset)
   begin
      if (!erx_io_nreset)
         frame_q <= 1'b0;
      else
         frame_q <= rx_frame;
   end

   always_ff @(posedge rx_lclk)
      word_q <= rx_word;                   // plain data path

   //################################################
   //# sample lanes
   //################################################

   // unselected lanes hold, so a burst keeps slots 0 to 2
   always_ff @(posedge rx_lclk)
   begin
      for (int k = 0; k < `ERX_SLOTS; k++)
      begin
         if (slot[k])
            sample[k*`ERX_WORD_W +: `ERX_WORD_W] <= word_q;
      end
   end

endmodule

`default_nettype wire

// File: design/erx_packet_mapper.sv
`timescale 1ns/10ps
`default_nettype none

module erx_packet_mapper
(
   input  wire              rx_lclk,
   input  wire              erx_io_nreset,
   input  wire              access,        // full sample ready
   input  wire              burst,         // packet is a burst follower
   input  wire erx_pkg::sample_t sample,   // raw 112 bit sample
   output logic             rx_access,     // one cycle strobe
   output logic             rx_burst,      // valid with rx_access, then held
   output erx_pkg::packet_t rx_packet      // valid with rx_access, then held
);

   import erx_pkg::*;

   packet_t packet_nxt;                    // reordered sample

   //################################################
   //# 112 bit sample to 104 bit packet
   //################################################

   // multibyte fields arrive big endian, byte lanes swap here
   always_comb
   begin
      packet_nxt[0]       = sample[40];                  // access
      packet_nxt[1]       = sample[41];                  // write
      packet_nxt[3:2]     = sample[43:42];               // datamode
      packet_nxt[7:4]     = sample[15:12];               // ctrlmode
      packet_nxt[39:8]    = {sample[11:8],               // dstaddr, top nibble
                             sample[23:16],
                             sample[31:24],
                             sample[39:32],
                             sample[47:44]};             // low nibble
      packet_nxt[71:40]   = {sample[55:48],              // data
                             sample[63:56],
                             sample[71:64],
                             sample[79:72]};
      packet_nxt[103:72]  = {sample[87:80],              // srcaddr
                             sample[95:88],
                             sample[103:96],
                             sample[111:104]};
   end

   //################################################
   //# output register
   //################################################

   always_ff @(posedge rx_lclk or negedge erx_io_nreset)
   begin
      if (!erx_io_nreset)
      begin
         rx_access <= 1'b0;
         rx_burst  <= 1'b0;
      end
      else
      begin
         rx_access <= access;
         if (access)
            rx_burst <= burst;
      end
   end

   always_ff @(posedge rx_lclk)
   begin
      if (access)
         rx_packet <= packet_nxt;          // holds until next access
   end

   // every lane must have been written before the first strobe
   a_packet_known : assert property (@(posedge rx_lclk) disable iff (!erx_io_nreset)
      rx_access |-> !$isunknown(rx_packet));

endmodule

`default_nettype wire

// File: design/erx_deframer.sv
`timescale 1ns/10ps
`default_nettype none

module erx_deframer
(
   input  wire              rx_lclk,
   input  wire              erx_io_nreset,
   input  wire              rx_frame,      // frame level, sampled
   input  wire erx_pkg::word_t rx_word,    // 16 bit word per edge
   output logic             rx_access,     // 2 cycles after last word
   output logic             rx_burst,
   output erx_pkg::packet_t rx_packet
);

   import erx_pkg::*;

   logic    frame_q;                       // registered frame
   logic    slot_clear;
   logic    slot_reload;
   logic    access;
   logic    burst;
   slot_t   slot;                          // write pointer
   sample_t sample;

   //################################################
   //# datapath and control
   //################################################

   erx_sample_assembler u_assembler
   (
      .rx_lclk       (rx_lclk),
      .erx_io_nreset (erx_io_nreset),
      .rx_frame      (rx_frame),
      .rx_word       (rx_word),
      .slot          (slot),
      .frame_q       (frame_q),
      .sample        (sample)
   );

   erx_slot_counter u_counter
   (
      .rx_lclk       (rx_lclk),
      .erx_io_nreset (erx_io_nreset),
      .slot_clear    (slot_clear),
      .slot_reload   (slot_reload),
      .slot          (slot)
   );

   erx_frame_fsm u_fsm
   (
      .rx_lclk       (rx_lclk),
      .erx_io_nreset (erx_io_nreset),
      .frame_q       (frame_q),
      .slot          (slot),
      .slot_clear    (slot_clear),
      .slot_reload   (slot_reload),
      .access        (access),
      .burst         (burst)
   );

   erx_packet_mapper u_mapper
   (
      .rx_lclk       (rx_lclk),
      .erx_io_nreset (erx_io_nreset),
      .access        (access),
      .burst         (burst),
      .sample        (sample),
      .rx_access     (rx_access),
      .rx_burst      (rx_burst),
      .rx_packet     (rx_packet)
   );

endmodule

`default_nettype wire

// File: verification/erx_tb.sv
`timescale 1ns/10ps
`default_nettype none

module erx_tb;

   import erx_pkg::*;

   // one expected output, as read from the data file
   typedef struct packed
   {
      logic    burst;
      packet_t pkt;
   } expect_t;

   logic    rx_lclk;
   logic    erx_io_nreset;
   logic    rx_frame;
   word_t   rx_word;
   logic    rx_access;
   logic    rx_burst;
   packet_t rx_packet;

   expect_t     expect_q[$];               // filled by the reader, drained by the monitor
   expect_t     exp_item;
   int          pkt_count;                 // packets checked so far
   int          fd;
   logic [31:0] rng_state;                 // xorshift state

   erx_deframer dut0
   (
      .rx_lclk       (rx_lclk),
      .erx_io_nreset (erx_io_nreset),
      .rx_frame      (rx_frame),
      .rx_word       (rx_word),
      .rx_access     (rx_access),
      .rx_burst      (rx_burst),
      .rx_packet     (rx_packet)
   );

   always #5 rx_lclk = ~rx_lclk;           // 10 ns period

   //################################################
   //# helpers
   //################################################

   task automatic stop_run(input string what);
      $display("%s", what);
      $display("TEST FAIL");
      $fatal(1, "stopped at the first error");
   endtask

   function automatic logic [31:0] xorshift32(input logic [31:0] x);
      logic [31:0] y;
      y = x ^ (x << 13);
      y = y ^ (y >> 17);
      y = y ^ (y << 5);
      return y;
   endfunction

   // one link cycle, inputs move 1 ns after the edge
   task automatic drive_word(input logic frame, input word_t word);
      @(posedge rx_lclk);
      #1;
      rx_frame = frame;
      rx_word  = word;
   endtask

   task automatic idle_gap();
      int gap;
      rng_state = xorshift32(rng_state);
      gap = int'(rng_state[1:0]) + 1;      // 1 to 4 cycles
      repeat (gap)
         drive_word(1'b0, '0);
   endtask

   task automatic check_burst(input logic got, input logic exp);
      if (got !== exp)
         stop_run($sformatf("Fail at %0d ns: packet %0d rx_burst got %b expected %b",
                            $time, pkt_count, got, exp));
   endtask

   // names the first field that differs, msb side first
   task automatic check_packet(input packet_t got, input packet_t exp);
      string field;
      if (got !== exp)
      begin
         if (got[103:72] !== exp[103:72])
            field = "srcaddr";
         else if (got[71:40] !== exp[71:40])
            field = "data";
         else if (got[39:8] !== exp[39:8])
            field = "dstaddr";
         else if (got[7:4] !== exp[7:4])
            field = "ctrlmode";
         else
            field = "datamode/write/access";
         stop_run($sformatf("Fail at %0d ns: packet %0d %s wrong, got %h expected %h",
                            $time, pkt_count, field, got, exp));
      end
   endtask

   //################################################
   //# stimulus from the data file
   //################################################

   task automatic play_stimulus();
      logic [7:0]       tag;
      logic [31:0]      fval;
      logic [8*128-1:0] rest;
      word_t            wval;
      packet_t          pval;
      expect_t          item;
      int               n;
      bit               done;
      done = 1'b0;
      while (!done)
      begin
         n = $fscanf(fd, "%s", tag);
         if (n != 1)
            done = 1'b1;                   // end of file
         else
         begin
            case (tag)
               "#" : n = $fgets(rest, fd);   // comment, skip the line
               "g" : idle_gap();
               "w" :
               begin
                  n = $fscanf(fd, "%h %h", fval, wval);
                  if (n != 2)
                     stop_run("a w line in the data file is malformed");
                  else
                     drive_word(fval[0], wval);
               end
               "e" :
               begin
                  n = $fscanf(fd, "%h %h", fval, pval);
                  if (n != 2)
                     stop_run("an e line in the data file is malformed");
                  else
                  begin
                     item.burst = fval[0];
                     item.pkt   = pval;
                     expect_q.push_back(item);
                  end
               end
               default : stop_run("the data file holds a line with an unknown tag");
            endcase
         end
      end
   endtask

   task automatic drain_and_finish();
      int waited;
      waited = 0;
      while (expect_q.size() != 0 && waited < 200)
      begin
         @(posedge rx_lclk);
         waited++;
      end
      if (expect_q.size() != 0)
         stop_run($sformatf("timeout, %0d expected packets never came out of the DUT",
                            expect_q.size()));
      else
      begin
         repeat (10)
            @(posedge rx_lclk);            // room for a stray pulse
         $display("TEST PASS");
         $finish;
      end
   endtask

   //################################################
   //# monitor, sampled mid cycle
   //################################################

   always @(negedge rx_lclk)
   begin
      if (erx_io_nreset && $isunknown(rx_access))
         stop_run("rx_access is unknown after reset");
      else if (rx_access === 1'b1)
      begin
         if (expect_q.size() == 0)
            stop_run("rx_access pulsed although no packet was expected");
         else
         begin
            exp_item = expect_q.pop_front();
            check_burst(rx_burst, exp_item.burst);
            check_packet(rx_packet, exp_item.pkt);
            pkt_count++;
         end
      end
   end

   initial
   begin
      rx_lclk       = 1'b0;
      erx_io_nreset = 1'b0;
      rx_frame      = 1'b0;
      rx_word       = '0;
      pkt_count     = 0;
      rng_state     = 32'hd967_aca5;
      fd = $fopen("verification/erx_testdata.txt", "r");
      if (fd == 0)
         stop_run("could not open verification/erx_testdata.txt");
      else
      begin
         repeat (16)
            @(posedge rx_lclk);            // reset held 16 cycles
         #1;
         erx_io_nreset = 1'b1;
         play_stimulus();
         $fclose(fd);
         drain_and_finish();
      end
   end

endmodule

`default_nettype wire

// File: verification/erx_testdata.txt
# w <frame> <word hex>  one link cycle    e <burst> <packet hex>  expected output
# g  idle gap of 1 to 4 cycles with the frame low
g
# single frame
w 1 5a00
w 1 3412
w 1 7b56
w 1 adde
w 1 efbe
w 1 0080
w 1 0010
e 0 80001000deadbeefa12345675b
g
# frame of 7 + 4 + 4 words
w 1 3c99
w 1 fe0f
w 1 26e1
w 1 2211
w 1 4433
w 1 6655
w 1 8877
e 0 5566778811223344c0ffee1236
w 1 feca
w 1 0df0
w 1 3412
w 1 7856
e 1 12345678cafef00dc0ffee1236
w 1 ad0b
w 1 0df0
w 1 bc9a
w 1 f0de
e 1 9abcdef00badf00dc0ffee1236
g
# frame dropped after five words
w 1 1111
w 1 2222
w 1 3333
w 1 4444
w 1 5555
g
# full frame, then one idle cycle, then the next frame
w 1 9700
w 1 1234
w 1 e4ab
w 1 0000
w 1 ffff
w 1 0102
w 1 0304
e 0 020104030000ffff73412abe94
w 0 0000
w 1 f123
w 1 0000
w 1 1f00
w 1 0110
w 1 2002
w 1 4321
w 1 8765
e 0 214365871001022010000001ff
g

// File: sources.f
+incdir+design
design/erx_pkg.sv
design/erx_frame_fsm.sv
design/erx_slot_counter.sv
design/erx_sample_assembler.sv
design/erx_packet_mapper.sv
design/erx_deframer.sv
verification/erx_tb.sv

// File: run_sim.sh
#!/bin/sh
# build and run the deframer testbench with verilator

cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --assert -f sources.f --top-module erx_tb -o erx_sim
if [ $? -ne 0 ]; then
   echo "verilator build failed"
   exit 1
fi

./obj_dir/erx_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
   echo "simulation exited with status $status"
   exit 1
fi

if grep -q "^TEST PASS$" sim.log; then
   exit 0
fi
echo "pass message not found in sim.log"
exit 1
